/* pam4_tx_config.svh */
`ifndef PAM4_TX_CONFIG_SVH
`define PAM4_TX_CONFIG_SVH

// Filter span in symbols
`define PAM4_SPAN 8

// Samples per symbol
`define PAM4_SPS 4

// System clocks per output sample
`define PAM4_CLK_PER_SAM 4

// Output sample width
`define PAM4_SAM_W 18

// SRRC coefficient width
`define PAM4_COEF_W 16

// Span times samples per symbol, plus the single trailing tap
`define PAM4_NTAPS 33

`endif

/* pam4_tx_pkg.sv */
`default_nettype none

`include "pam4_tx_config.svh"

package pam4_tx_pkg;

    // Symbol codes, SYM_ZERO is the idle level
    typedef enum logic [2:0] {
        SYM_ZERO = 3'd0,
        SYM_P1   = 3'd1,
        SYM_P3   = 3'd2,
        SYM_N1   = 3'd3,
        SYM_N3   = 3'd4
    } sym_t;

    typedef enum logic [1:0] {
        MODE_PRBS    = 2'd0,
        MODE_FIXED   = 2'd1,
        MODE_IMPULSE = 2'd2
    } src_mode_t;

    // Wishbone register word addresses
    typedef enum logic [1:0] {
        REG_CTRL   = 2'd0,
        REG_FIXED  = 2'd1,
        REG_SEED   = 2'd2,
        REG_STATUS = 2'd3
    } reg_addr_t;

    // SRRC taps at 4 samples per symbol, centre tap at index 16
    parameter logic signed [`PAM4_COEF_W-1:0] srrc_coef [`PAM4_NTAPS] = '{
          16'sd160,    16'sd30,  -16'sd220,  -16'sd360,  -16'sd250,   16'sd120,
          16'sd520,   16'sd640,   16'sd260,  -16'sd480, -16'sd1160, -16'sd1180,
         -16'sd110,  16'sd2050,  16'sd4870,  16'sd7260,  16'sd8192,  16'sd7260,
         16'sd4870,  16'sd2050,  -16'sd110, -16'sd1180, -16'sd1160,  -16'sd480,
          16'sd260,   16'sd640,   16'sd520,   16'sd120,  -16'sd250,  -16'sd360,
         -16'sd220,    16'sd30,   16'sd160
    };

    // Amplitude of a symbol, undefined codes count as idle
    function automatic logic signed [2:0] sym_level(sym_t s);
        case (s)
            SYM_P1:  return 3'sd1;
            SYM_P3:  return 3'sd3;
            SYM_N1:  return -3'sd1;
            SYM_N3:  return -3'sd3;
            default: return 3'sd0;
        endcase
    endfunction

endpackage

`default_nettype wire

/* pam4_tx_clk_en.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pam4_tx_config.svh"

module pam4_tx_clk_en (
    input  logic       clk,
    input  logic       reset,
    output logic       sam_en,
    output logic       sym_en,
    output logic [1:0] phase
);

    localparam int CPS   = `PAM4_CLK_PER_SAM;
    localparam int SPS   = `PAM4_SPS;
    localparam int CNT_W = (CPS > 1) ? $clog2(CPS) : 1;

    logic [CNT_W-1:0] clk_cnt;
    // Index of the next sample within its symbol
    logic [1:0]       sam_idx;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            clk_cnt <= '0;
            sam_idx <= 2'd0;
            sam_en  <= 1'b0;
            sym_en  <= 1'b0;
            phase   <= 2'd0;
        end else if (clk_cnt == CNT_W'(CPS - 1)) begin
            clk_cnt <= '0;
            sam_en  <= 1'b1;
            sym_en  <= (sam_idx == 2'd0);
            phase   <= sam_idx;
            sam_idx <= (sam_idx == 2'(SPS - 1)) ? 2'd0 : sam_idx + 2'd1;
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
            sam_en  <= 1'b0;
            sym_en  <= 1'b0;
        end
    end

    // Symbol strobe only on a phase 0 sample strobe
    a_sym_on_sam: assert property (@(posedge clk) disable iff (reset)
        sym_en |-> (sam_en && phase == 2'd0));

endmodule

`default_nettype wire

/* pam4_tx_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module pam4_tx_regs (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [1:0]              wb_adr,
    input  logic [15:0]             wb_dat_i,
    output logic [15:0]             wb_dat_o,
    output logic                    wb_ack,
    output logic                    enable,
    output pam4_tx_pkg::src_mode_t  mode,
    output pam4_tx_pkg::sym_t       fixed_sym,
    output logic [15:0]             seed,
    output logic                    seed_load,
    input  logic                    sym_issued
);

    logic        req;
    logic [15:0] rd_data;
    logic [15:0] sym_cnt;

    // New request, ack not yet given
    assign req = wb_cyc && wb_stb && !wb_ack;

    always_comb begin
        case (pam4_tx_pkg::reg_addr_t'(wb_adr))
            pam4_tx_pkg::REG_CTRL:   rd_data = {13'd0, mode, enable};
            pam4_tx_pkg::REG_FIXED:  rd_data = {13'd0, fixed_sym};
            pam4_tx_pkg::REG_SEED:   rd_data = seed;
            default:                 rd_data = sym_cnt;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_ack    <= 1'b0;
            wb_dat_o  <= 16'd0;
            enable    <= 1'b0;
            mode      <= pam4_tx_pkg::MODE_PRBS;
            fixed_sym <= pam4_tx_pkg::SYM_ZERO;
            seed      <= 16'h0001;
            seed_load <= 1'b0;
        end else begin
            wb_ack    <= req;
            seed_load <= 1'b0;
            if (req) begin
                wb_dat_o <= rd_data;
                if (wb_we) begin
                    case (pam4_tx_pkg::reg_addr_t'(wb_adr))
                        pam4_tx_pkg::REG_CTRL: begin
                            enable <= wb_dat_i[0];
                            mode   <= pam4_tx_pkg::src_mode_t'(wb_dat_i[2:1]);
                        end
                        pam4_tx_pkg::REG_FIXED: begin
                            fixed_sym <= pam4_tx_pkg::sym_t'(wb_dat_i[2:0]);
                        end
                        pam4_tx_pkg::REG_SEED: begin
                            // An all-zero LFSR would lock up
                            seed      <= (wb_dat_i == 16'd0) ? 16'h0001 : wb_dat_i;
                            seed_load <= 1'b1;
                        end
                        default: begin
                            // Status is read-only
                        end
                    endcase
                end
            end
        end
    end

    // Symbols issued since reset, wraps at 16 bits
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sym_cnt <= 16'd0;
        end else if (sym_issued) begin
            sym_cnt <= sym_cnt + 16'd1;
        end
    end

    a_ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
        wb_ack |-> (wb_cyc && wb_stb));

endmodule

`default_nettype wire

/* pam4_symbol_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module pam4_symbol_gen (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    sym_en,
    input  logic                    enable,
    input  pam4_tx_pkg::src_mode_t  mode,
    input  pam4_tx_pkg::sym_t       fixed_sym,
    input  logic [15:0]             seed,
    input  logic                    seed_load,
    output pam4_tx_pkg::sym_t       sym,
    output logic                    sym_issued
);

    logic [15:0] lfsr;
    logic        lfsr_fb;
    logic        imp_done;

    // Fibonacci taps 16, 14, 13, 11
    assign lfsr_fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    function automatic pam4_tx_pkg::sym_t bits_to_sym(logic [1:0] b);
        case (b)
            2'b00:   return pam4_tx_pkg::SYM_N3;
            2'b01:   return pam4_tx_pkg::SYM_N1;
            2'b10:   return pam4_tx_pkg::SYM_P1;
            default: return pam4_tx_pkg::SYM_P3;
        endcase
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr       <= 16'h0001;
            imp_done   <= 1'b0;
            sym        <= pam4_tx_pkg::SYM_ZERO;
            sym_issued <= 1'b0;
        end else begin
            sym_issued <= 1'b0;
            if (seed_load) begin
                lfsr <= seed;
            end
            // Impulse rearms whenever it is not the active mode
            if (!enable || mode != pam4_tx_pkg::MODE_IMPULSE) begin
                imp_done <= 1'b0;
            end
            if (sym_en) begin
                if (!enable) begin
                    sym <= pam4_tx_pkg::SYM_ZERO;
                end else begin
                    sym_issued <= 1'b1;
                    case (mode)
                        pam4_tx_pkg::MODE_PRBS: begin
                            sym <= bits_to_sym(lfsr[1:0]);
                            if (!seed_load) begin
                                lfsr <= {lfsr[14:0], lfsr_fb};
                            end
                        end
                        pam4_tx_pkg::MODE_FIXED: begin
                            // Undefined codes from the register go out as idle
                            if (fixed_sym inside {pam4_tx_pkg::SYM_P1, pam4_tx_pkg::SYM_P3,
                                                  pam4_tx_pkg::SYM_N1, pam4_tx_pkg::SYM_N3}) begin
                                sym <= fixed_sym;
                            end else begin
                                sym <= pam4_tx_pkg::SYM_ZERO;
                            end
                        end
                        pam4_tx_pkg::MODE_IMPULSE: begin
                            sym      <= imp_done ? pam4_tx_pkg::SYM_ZERO : pam4_tx_pkg::SYM_P3;
                            imp_done <= 1'b1;
                        end
                        default: begin
                            sym <= pam4_tx_pkg::SYM_ZERO;
                        end
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

/* srrc_lut_filter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pam4_tx_config.svh"

module srrc_lut_filter (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          sam_en,
    input  logic                          sym_en,
    input  logic [1:0]                    phase,
    input  pam4_tx_pkg::sym_t             sym,
    output logic signed [`PAM4_SAM_W-1:0] sample,
    output logic                          sample_valid
);

    localparam int SPAN  = `PAM4_SPAN;
    localparam int SPS   = `PAM4_SPS;
    localparam int SW    = `PAM4_SAM_W;
    localparam int NSYM  = 5;
    localparam int ACC_W = SW + $clog2(SPAN + 1);

    localparam logic signed [ACC_W-1:0] SAT_MAX = (2 ** (SW - 1)) - 1;
    localparam logic signed [ACC_W-1:0] SAT_MIN = -(2 ** (SW - 1));

    // Taps past the end of the table read as zero
    function automatic int tap_coef(int idx);
        if (idx >= `PAM4_NTAPS) begin
            return 0;
        end
        return int'(pam4_tx_pkg::srrc_coef[idx]);
    endfunction

    pam4_tx_pkg::sym_t        hist [SPAN + 1];
    logic signed [SW-1:0]     slot_prod [SPAN + 1];
    logic signed [ACC_W-1:0]  acc;
    logic signed [SW-1:0]     acc_sat;
    logic [1:0]               phase_q;
    logic                     sum_pend;

    // Symbol history, slot 0 is the newest symbol
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int k = 0; k <= SPAN; k++) begin
                hist[k] <= pam4_tx_pkg::SYM_ZERO;
            end
        end else if (sym_en) begin
            hist[0] <= sym;
            for (int k = 1; k <= SPAN; k++) begin
                hist[k] <= hist[k-1];
            end
        end
    end

    // One product table per slot, indexed by phase and symbol code
    for (genvar k = 0; k <= SPAN; k++) begin : g_slot
        logic signed [SW-1:0] tab [SPS][NSYM];

        for (genvar p = 0; p < SPS; p++) begin : g_phase
            localparam int C = tap_coef(SPS * k + p);

            assign tab[p][pam4_tx_pkg::SYM_ZERO] = '0;
            assign tab[p][pam4_tx_pkg::SYM_P1]   = SW'(C);
            assign tab[p][pam4_tx_pkg::SYM_P3]   = SW'(3 * C);
            assign tab[p][pam4_tx_pkg::SYM_N1]   = SW'(-C);
            assign tab[p][pam4_tx_pkg::SYM_N3]   = SW'(-3 * C);
        end

        assign slot_prod[k] = (hist[k] <= pam4_tx_pkg::SYM_N3) ?
                              tab[phase_q][hist[k]] : '0;
    end

    // Sum of all slot products
    always_comb begin
        acc = '0;
        for (int k = 0; k <= SPAN; k++) begin
            acc = acc + ACC_W'(slot_prod[k]);
        end
    end

    always_comb begin
        if (acc > SAT_MAX) begin
            acc_sat = SAT_MAX[SW-1:0];
        end else if (acc < SAT_MIN) begin
            acc_sat = SAT_MIN[SW-1:0];
        end else begin
            acc_sat = acc[SW-1:0];
        end
    end

    // Phase is latched with the sample strobe, output follows one clock later
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase_q      <= 2'd0;
            sum_pend     <= 1'b0;
            sample       <= '0;
            sample_valid <= 1'b0;
        end else begin
            sum_pend     <= sam_en;
            sample_valid <= sum_pend;
            if (sam_en) begin
                phase_q <= phase;
            end
            if (sum_pend) begin
                sample <= acc_sat;
            end
        end
    end

    a_hist_defined: assert property (@(posedge clk) disable iff (reset)
        sym_en |=> hist[0] inside {pam4_tx_pkg::SYM_ZERO, pam4_tx_pkg::SYM_P1,
                                   pam4_tx_pkg::SYM_P3, pam4_tx_pkg::SYM_N1,
                                   pam4_tx_pkg::SYM_N3});

endmodule

`default_nettype wire

/* pam4_tx_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pam4_tx_config.svh"

module pam4_tx_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [1:0]                    wb_adr,
    input  logic [15:0]                   wb_dat_i,
    output logic [15:0]                   wb_dat_o,
    output logic                          wb_ack,
    output logic signed [`PAM4_SAM_W-1:0] sample,
    output logic                          sample_valid
);

    logic                   enable;
    pam4_tx_pkg::src_mode_t mode;
    pam4_tx_pkg::sym_t      fixed_sym;
    logic [15:0]            seed;
    logic                   seed_load;
    logic                   sym_issued;
    logic                   sam_en;
    logic                   sym_en;
    logic [1:0]             phase;
    pam4_tx_pkg::sym_t      sym;

    pam4_tx_regs regs_i (
        .clk        (clk),
        .reset      (reset),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_i   (wb_dat_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack     (wb_ack),
        .enable     (enable),
        .mode       (mode),
        .fixed_sym  (fixed_sym),
        .seed       (seed),
        .seed_load  (seed_load),
        .sym_issued (sym_issued)
    );

    pam4_tx_clk_en clk_en_i (
        .clk    (clk),
        .reset  (reset),
        .sam_en (sam_en),
        .sym_en (sym_en),
        .phase  (phase)
    );

    pam4_symbol_gen symbol_gen_i (
        .clk        (clk),
        .reset      (reset),
        .sym_en     (sym_en),
        .enable     (enable),
        .mode       (mode),
        .fixed_sym  (fixed_sym),
        .seed       (seed),
        .seed_load  (seed_load),
        .sym        (sym),
        .sym_issued (sym_issued)
    );

    srrc_lut_filter filter_i (
        .clk          (clk),
        .reset        (reset),
        .sam_en       (sam_en),
        .sym_en       (sym_en),
        .phase        (phase),
        .sym          (sym),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter real PERIOD = 10.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2.0) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* tb_pam4_tx.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pam4_tx_config.svh"

module tb_pam4_tx;

    localparam int SPAN     = `PAM4_SPAN;
    localparam int SPS      = `PAM4_SPS;
    localparam int NTAPS    = `PAM4_NTAPS;
    localparam int SYM_CLKS = `PAM4_SPS * `PAM4_CLK_PER_SAM;
    localparam int N_RUN    = 20;
    localparam int FLUSH    = (SPAN + 3) * SPS;
    // Symbol periods used by the tests with bus traffic rounded in
    localparam int TEST_SYMS = 5 + 14 + (2 * (SPAN + 3) + 4) + 52 + (N_RUN + 2 * (SPAN + 3) + 4);

    logic                          clk;
    logic                          reset;
    logic                          wb_cyc;
    logic                          wb_stb;
    logic                          wb_we;
    logic [1:0]                    wb_adr;
    logic [15:0]                   wb_dat_i;
    logic [15:0]                   wb_dat_o;
    logic                          wb_ack;
    logic signed [`PAM4_SAM_W-1:0] sample;
    logic                          sample_valid;

    int     errors;
    int     checks;
    int     sam_cnt;
    integer seed;

    tb_clock_gen #(.PERIOD(10.0)) clock_gen_i (.clk(clk));

    pam4_tx_top pam4_tx_top_i (
        .clk          (clk),
        .reset        (reset),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_i     (wb_dat_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack       (wb_ack),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    // Samples seen since reset starting at phase 0
    always @(posedge clk) begin
        if (reset) begin
            sam_cnt <= 0;
        end else if (sample_valid) begin
            sam_cnt <= sam_cnt + 1;
        end
    end

    initial begin
        #(TEST_SYMS * SYM_CLKS * 10 + 20000);
        $display("Watchdog expired at %0t, the tests did not finish", $time);
        $display("Result: FAILED");
        $finish;
    end

    // LFSR low bits to amplitude
    function automatic int bits_to_level(logic [1:0] b);
        case (b)
            2'b00:   return -3;
            2'b01:   return -1;
            2'b10:   return 1;
            default: return 3;
        endcase
    endfunction

    function automatic logic [15:0] next_lfsr(logic [15:0] l);
        return {l[14:0], l[15] ^ l[13] ^ l[12] ^ l[10]};
    endfunction

    // Taps past the end of the table are zero
    function automatic int coef_at(int i);
        if (i >= NTAPS) begin
            return 0;
        end
        return int'(pam4_tx_pkg::srrc_coef[i]);
    endfunction

    function automatic logic [15:0] ctrl_word(pam4_tx_pkg::src_mode_t m, logic en);
        return {13'd0, m, en};
    endfunction

    task automatic check_int(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("Failure at %0t: %s", $time, what);
    endtask

    task automatic wb_access(input pam4_tx_pkg::reg_addr_t addr, input logic we,
                             input logic [15:0] wdata, output logic [15:0] rdata);
        int n;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= addr;
        wb_dat_i <= wdata;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!wb_ack && n < 16);
        if (!wb_ack) begin
            report_failure("wb_ack never came for a bus request");
        end else begin
            check_int("wb_ack latency", n, 2);
        end
        rdata = wb_dat_o;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input pam4_tx_pkg::reg_addr_t addr, input logic [15:0] data);
        logic [15:0] unused;
        wb_access(addr, 1'b1, data, unused);
    endtask

    task automatic wb_read(input pam4_tx_pkg::reg_addr_t addr, output logic [15:0] data);
        wb_access(addr, 1'b0, 16'd0, data);
    endtask

    // Next sample and its phase within the symbol
    task automatic get_sample(output int v, output int p);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!sample_valid && n < 2 * SYM_CLKS);
        if (!sample_valid) begin
            report_failure("sample_valid stopped pulsing");
        end
        v = int'(sample);
        p = sam_cnt % SPS;
    endtask

    task automatic skip_samples(input int count);
        int v;
        int p;
        for (int i = 0; i < count; i++) begin
            get_sample(v, p);
        end
    endtask

    task automatic wait_nonzero(output int v, output int p);
        int n;
        n = 0;
        do begin
            get_sample(v, p);
            n++;
        end while (v == 0 && n < 16 * SPS);
        if (v == 0) begin
            report_failure("output stayed zero after the source was enabled");
        end
    endtask

    task automatic test_reset_regs();
        logic [15:0] d;
        wb_read(pam4_tx_pkg::REG_CTRL, d);
        check_int("REG_CTRL", d, 0);
        wb_read(pam4_tx_pkg::REG_FIXED, d);
        check_int("REG_FIXED", d, 0);
        wb_read(pam4_tx_pkg::REG_SEED, d);
        check_int("REG_SEED", d, 1);
        wb_read(pam4_tx_pkg::REG_STATUS, d);
        check_int("REG_STATUS", d, 0);
        wb_write(pam4_tx_pkg::REG_CTRL, ctrl_word(pam4_tx_pkg::MODE_FIXED, 1'b0));
        wb_read(pam4_tx_pkg::REG_CTRL, d);
        check_int("REG_CTRL", d, 2);
        wb_write(pam4_tx_pkg::REG_FIXED, 16'd3);
        wb_read(pam4_tx_pkg::REG_FIXED, d);
        check_int("REG_FIXED", d, 3);
        wb_write(pam4_tx_pkg::REG_SEED, 16'hBEEF);
        wb_read(pam4_tx_pkg::REG_SEED, d);
        check_int("REG_SEED", d, 16'hBEEF);
        // Zero seed turns into one
        wb_write(pam4_tx_pkg::REG_SEED, 16'h0000);
        wb_read(pam4_tx_pkg::REG_SEED, d);
        check_int("REG_SEED", d, 1);
        wb_write(pam4_tx_pkg::REG_CTRL, ctrl_word(pam4_tx_pkg::MODE_PRBS, 1'b0));
        wb_read(pam4_tx_pkg::REG_STATUS, d);
        check_int("REG_STATUS", d, 0);
    endtask

    task automatic test_impulse();
        int v;
        int p;
        wb_write(pam4_tx_pkg::REG_CTRL, ctrl_word(pam4_tx_pkg::MODE_IMPULSE, 1'b1));
        wait_nonzero(v, p);
        check_int("sample phase", p, 0);
        for (int i = 0; i < NTAPS; i++) begin
            if (i > 0) begin
                get_sample(v, p);
            end
            check_int("sample", v, 3 * coef_at(i));
        end
        for (int i = 0; i < 2 * SPS; i++) begin
            get_sample(v, p);
            check_int("sample", v, 0);
        end
        wb_write(pam4_tx_pkg::REG_CTRL, ctrl_word(pam4_tx_pkg::MODE_PRBS, 1'b0));
    endtask

    task automatic test_fixed();
        pam4_tx_pkg::sym_t s;
        int                psum [SPS];
        int                v;
        int                p;
        case ($unsigned($random(seed)) % 4)
            0:       s = pam4_tx_pkg::SYM_P1;
            1:       s = pam4_tx_pkg::SYM_P3;
            2:       s = pam4_tx_pkg::SYM_N1;
            default: s = pam4_tx_pkg::SYM_N3;
        endcase
        $display("Fixed symbol test with %s", s.name());
        // Steady state output per phase is the level times the polyphase sum
        for (int ph = 0; ph < SPS; ph++) begin
            psum[ph] = 0;
            for (int k = 0; k <= SPAN; k++) begin
                psum[ph] += coef_at(SPS * k + ph);
            end
        end
        wb_write(pam4_tx_pkg::REG_FIXED, {13'd0, s});
        wb_write(pam4_tx_pkg::REG_CTRL, ctrl_word(pam4_tx_pkg::MODE_FIXED, 1'b1));
        skip_samples(FLUSH);
        for (int i = 0; i < 4 * SPS; i++) begin
            get_sample(v, p);
            check_int("sample", v, int'(pam4_tx_pkg::sym_level(s)) * psum[p]);
        end
        wb_write(pam4_tx_pkg::REG_CTRL, ctrl_word(pam4_tx_pkg::MODE_FIXED, 1'b0));
        skip_samples(FLUSH);
    endtask

    task automatic test_prbs();
        logic [15:0] lfsr;
        int          lv [64];
        int          v;
        int          p;
        int          j;
        int          ex;
        lfsr = 16'hACE1;
        for (int i = 0; i < 64; i++) begin
            lv[i] = bits_to_level(lfsr[1:0]);
            lfsr  = next_lfsr(lfsr);
        end
        wb_write(pam4_tx_pkg::REG_SEED, 16'hACE1);
        wb_write(pam4_tx_pkg::REG_CTRL, ctrl_word(pam4_tx_pkg::MODE_PRBS, 1'b1));
        wait_nonzero(v, p);
        check_int("sample phase", p, 0);
        for (int n = 0; n < 200; n++) begin
            if (n > 0) begin
                get_sample(v, p);
            end
            j  = n / SPS;
            ex = 0;
            for (int k = 0; k <= SPAN && k <= j; k++) begin
                ex += lv[j - k] * coef_at(SPS * k + n % SPS);
            end
            check_int("sample", v, ex);
        end
    endtask

    task automatic test_disable_count();
        logic [15:0] c0;
        logic [15:0] c1;
        logic [15:0] c2;
        int          d;
        int          v;
        int          p;
        wb_write(pam4_tx_pkg::REG_CTRL, ctrl_word(pam4_tx_pkg::MODE_PRBS, 1'b0));
        wb_read(pam4_tx_pkg::REG_STATUS, c0);
        wb_write(pam4_tx_pkg::REG_CTRL, ctrl_word(pam4_tx_pkg::MODE_PRBS, 1'b1));
        skip_samples(N_RUN * SPS);
        wb_write(pam4_tx_pkg::REG_CTRL, ctrl_word(pam4_tx_pkg::MODE_PRBS, 1'b0));
        wb_read(pam4_tx_pkg::REG_STATUS, c1);
        d = int'(c1 - c0);
        checks++;
        if (d < N_RUN - 1 || d > N_RUN + 1) begin
            errors++;
            $display("Error at %0t: REG_STATUS rose by %0d, expected %0d within one",
                     $time, d, N_RUN);
        end
        skip_samples(FLUSH);
        wb_read(pam4_tx_pkg::REG_STATUS, c2);
        check_int("REG_STATUS", c2, c1);
        for (int i = 0; i < 2 * SPS; i++) begin
            get_sample(v, p);
            check_int("sample", v, 0);
        end
    endtask

    initial begin
        errors   = 0;
        checks   = 0;
        seed     = 16;
        reset    = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = 2'd0;
        wb_dat_i = 16'd0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        test_reset_regs();
        test_impulse();
        test_fixed();
        test_prbs();
        test_disable_count();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* pam4_tx.f */
+incdir+.
pam4_tx_pkg.sv
pam4_tx_clk_en.sv
pam4_tx_regs.sv
pam4_symbol_gen.sv
srrc_lut_filter.sv
pam4_tx_top.sv
tb_clock_gen.sv
tb_pam4_tx.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_pam4_tx
FILELIST = pam4_tx.f
OBJDIR   = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf $(OBJDIR)
